// File: conv_macros.svh
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// datapath widths
`define CONV_QUAN_BITS   8      // one sample or one weight
`define CONV_PROD_BITS   16     // 8x8 signed product
`define CONV_ACC_BITS    20     // nine full-scale products still fit
`define CONV_TAPS        9
`define CONV_WIDX_BITS   4      // weight index taken from the low address bits

// result queue
`define CONV_FIFO_DEPTH  8      // power of two, pointers wrap on their own
`define CONV_PTR_BITS    3
`define CONV_CNT_BITS    4      // holds 0 .. depth

// wishbone side
`define CONV_ADR_BITS    8
`define CONV_DAT_BITS    32

// register map, word addresses
`define CONV_ADR_WEIGHT0 8'h00  // weights at 0x00 .. 0x08
`define CONV_ADR_CTRL    8'h10
`define CONV_ADR_SAMPLE  8'h14
`define CONV_ADR_RESULT  8'h18  // read pops
`define CONV_ADR_STATUS  8'h1C

`define CONV_CTRL_CLEAR_BIT 0
`define CONV_STAT_EMPTY_BIT 8
`define CONV_STAT_FULL_BIT  9

`endif

// File: conv_pkg.sv
`include "conv_macros.svh"

package conv_pkg;

    // arithmetic types, all signed
    typedef logic signed [`CONV_QUAN_BITS-1:0] quant_t;  // sample / weight
    typedef logic signed [`CONV_PROD_BITS-1:0] prod_t;   // registered product
    typedef logic signed [`CONV_ACC_BITS-1:0]  acc_t;    // partial sum, result

    // bus vectors
    typedef logic [`CONV_DAT_BITS-1:0] wb_word_t;
    typedef logic [`CONV_ADR_BITS-1:0] wb_adr_t;

    // host -> engine
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_adr_t  adr;
        wb_word_t dat_w;
    } wb_req_t;

    // engine -> host
    typedef struct packed {
        logic     ack;    // one cycle per access
        wb_word_t dat_r;
    } wb_rsp_t;

    // element k goes to tap k
    typedef quant_t [`CONV_TAPS-1:0] weight_bank_t;

    // bus handshake states
    typedef enum logic [1:0] {
        wb_idle,
        wb_wait_space,  // sample write held back, no fifo room
        wb_respond
    } wb_state_e;

endpackage

// File: mac_unit.sv
module mac_unit (
    input  logic             s_clk,
    input  logic             s_rst,
    input  conv_pkg::quant_t weight,    // held stable by the port
    input  conv_pkg::quant_t sample,    // broadcast to all taps
    input  logic             issue,
    input  logic             clear,
    input  conv_pkg::acc_t   shift_in,  // sum from tap k+1
    output conv_pkg::acc_t   mac_out
);

    conv_pkg::prod_t prod;     // stage 1 result
    logic            issue_d;  // prod is fresh

    // stage 1, registered multiply
    // 16-bit context sign-extends both operands
    always_ff @(posedge s_clk) begin
        if (issue)
            prod <= sample * weight;
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst)
            issue_d <= 1'b0;
        else
            issue_d <= issue;
    end

    // stage 2, add neighbour's old sum
    // every tap updates on the same edge, so shift_in is still
    // the neighbour's value from the previous sample
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            mac_out <= '0;
        end else if (clear) begin
            mac_out <= '0;                 // forget earlier samples
        end else if (issue_d) begin
            mac_out <= prod + shift_in;    // prod widened to acc width
        end
    end

endmodule

// File: mac_chain.sv
`include "conv_macros.svh"

module mac_chain (
    input  logic                   s_clk,
    input  logic                   s_rst,
    input  conv_pkg::weight_bank_t weights,
    input  conv_pkg::quant_t       sample,
    input  logic                   issue,
    input  logic                   clear,
    output logic                   result_valid,
    output conv_pkg::acc_t         result
);

    // link[k] is mac_out of tap k, link[taps] is the zero feed
    conv_pkg::acc_t link [0:`CONV_TAPS];
    logic [1:0]     vld_pipe;   // tracks issue through mult and add

    assign link[`CONV_TAPS] = '0;   // nothing above the last tap

    // transposed form
    // tap k computes w[k]*x[n] + (tap k+1 sum at n-1)
    // so tap 0 holds sum over k of w[k]*x[n-k]
    genvar k;
    generate
        for (k = 0; k < `CONV_TAPS; k++) begin : g_tap
            mac_unit u_mac (
                .s_clk    (s_clk),
                .s_rst    (s_rst),
                .weight   (weights[k]),
                .sample   (sample),
                .issue    (issue),
                .clear    (clear),
                .shift_in (link[k+1]),
                .mac_out  (link[k])
            );
        end
    endgenerate

    // valid follows issue by two edges, same as the pe pipe
    // clear leaves it alone so the fifo reservation is always released
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst)
            vld_pipe <= '0;
        else
            vld_pipe <= {vld_pipe[0], issue};
    end

    assign result_valid = vld_pipe[1];
    assign result       = link[0];      // y[n] from tap zero

endmodule

// File: result_fifo.sv
`include "conv_macros.svh"

module result_fifo (
    input  logic                      s_clk,
    input  logic                      s_rst,
    input  logic                      issue,    // reserve a slot
    input  logic                      push,     // reserved result arrives
    input  conv_pkg::acc_t            din,
    input  logic                      pop,
    output conv_pkg::acc_t            head,
    output logic                      empty,
    output logic                      full,
    output logic                      space,
    output logic [`CONV_CNT_BITS-1:0] count
);

    localparam logic [`CONV_CNT_BITS-1:0] depth_cnt = `CONV_FIFO_DEPTH;

    conv_pkg::acc_t            mem [`CONV_FIFO_DEPTH];
    logic [`CONV_PTR_BITS-1:0] wr_ptr;
    logic [`CONV_PTR_BITS-1:0] rd_ptr;
    logic [`CONV_CNT_BITS-1:0] cnt;        // stored entries
    logic [`CONV_CNT_BITS-1:0] resv;       // samples still in the chain
    logic [`CONV_CNT_BITS:0]   committed;  // stored + reserved
    logic                      do_push;
    logic                      do_pop;

    assign do_push = push && !full;       // reservation should make this always true
    assign do_pop  = pop && !empty;

    // storage, no reset
    always_ff @(posedge s_clk) begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
            resv   <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
            // a push turns one reservation into a stored entry
            case ({issue, push})
                2'b10:   resv <= resv + 1'b1;
                2'b01:   resv <= resv - 1'b1;
                default: resv <= resv;
            endcase
        end
    end

    assign committed = {1'b0, cnt} + {1'b0, resv};
    assign space     = committed < {1'b0, depth_cnt};
    assign empty     = cnt == '0;
    assign full      = cnt == depth_cnt;
    assign count     = cnt;
    assign head      = mem[rd_ptr];   // show-ahead

endmodule

// File: wb_slave_port.sv
`include "conv_macros.svh"

module wb_slave_port (
    input  logic                      s_clk,
    input  logic                      s_rst,
    input  conv_pkg::wb_req_t         wb_req,
    output conv_pkg::wb_rsp_t         wb_rsp,
    input  logic                      space,    // fifo can take one more sample
    input  conv_pkg::acc_t            head,
    input  logic                      empty,
    input  logic                      full,
    input  logic [`CONV_CNT_BITS-1:0] count,
    output conv_pkg::weight_bank_t    weights,
    output conv_pkg::quant_t          sample,
    output logic                      issue,
    output logic                      clear,
    output logic                      pop
);

    localparam logic [`CONV_ADR_BITS-1:0] n_taps = `CONV_TAPS;

    conv_pkg::wb_state_e state;
    conv_pkg::wb_word_t  rd_data;   // read mux output
    conv_pkg::wb_adr_t   widx;      // address relative to weight base
    conv_pkg::quant_t    wsel;      // addressed weight
    logic                req;       // new request, not yet answered
    logic                is_weight;
    logic                is_sample;
    logic                is_ctrl;
    logic                is_result;

    // ack still high means this request was just answered
    assign req       = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    assign widx      = wb_req.adr - `CONV_ADR_WEIGHT0;   // below base wraps high
    assign is_weight = widx < n_taps;
    assign is_ctrl   = wb_req.adr == `CONV_ADR_CTRL;
    assign is_sample = wb_req.we && (wb_req.adr == `CONV_ADR_SAMPLE);
    assign is_result = wb_req.adr == `CONV_ADR_RESULT;
    assign wsel      = weights[widx[`CONV_WIDX_BITS-1:0]];

    // read mux gives zero for unmapped addresses
    always_comb begin
        rd_data = '0;
        if (is_weight) begin
            rd_data = {{(`CONV_DAT_BITS-`CONV_QUAN_BITS){wsel[`CONV_QUAN_BITS-1]}}, wsel};
        end else if (is_result) begin
            if (!empty)                                         // empty fifo reads as zero
                rd_data = {{(`CONV_DAT_BITS-`CONV_ACC_BITS){head[`CONV_ACC_BITS-1]}}, head};
        end else if (wb_req.adr == `CONV_ADR_STATUS) begin
            rd_data[`CONV_CNT_BITS-1:0]      = count;
            rd_data[`CONV_STAT_EMPTY_BIT]    = empty;
            rd_data[`CONV_STAT_FULL_BIT]     = full;
        end
    end

    // handshake fsm plus register bank
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state   <= conv_pkg::wb_idle;
            wb_rsp  <= '0;
            issue   <= 1'b0;
            clear   <= 1'b0;
            pop     <= 1'b0;
            weights <= '0;
        end else begin
            wb_rsp.ack <= 1'b0;   // pulses last one cycle
            issue      <= 1'b0;
            clear      <= 1'b0;
            pop        <= 1'b0;
            case (state)
                conv_pkg::wb_idle: begin
                    if (req) begin
                        // samples need a reserved fifo slot first
                        if (is_sample && !space)
                            state <= conv_pkg::wb_wait_space;
                        else
                            state <= conv_pkg::wb_respond;
                    end
                end
                conv_pkg::wb_wait_space: begin
                    if (!(req && is_sample))   // write withdrawn, other accesses go on
                        state <= conv_pkg::wb_idle;
                    else if (space)            // host popped a result
                        state <= conv_pkg::wb_respond;
                end
                conv_pkg::wb_respond: begin
                    state        <= conv_pkg::wb_idle;
                    wb_rsp.ack   <= 1'b1;
                    wb_rsp.dat_r <= wb_req.we ? '0 : rd_data;
                    if (wb_req.we) begin
                        if (is_weight)
                            weights[widx[`CONV_WIDX_BITS-1:0]] <=
                                wb_req.dat_w[`CONV_QUAN_BITS-1:0];
                        if (is_ctrl)
                            clear <= wb_req.dat_w[`CONV_CTRL_CLEAR_BIT];
                        if (is_sample)
                            issue <= 1'b1;     // lines up with ack
                    end else if (is_result && !empty) begin
                        pop <= 1'b1;           // head already latched into dat_r
                    end
                end
                default: state <= conv_pkg::wb_idle;
            endcase
        end
    end

    // sample payload latched along with issue
    always_ff @(posedge s_clk) begin
        if (state == conv_pkg::wb_respond && is_sample)
            sample <= wb_req.dat_w[`CONV_QUAN_BITS-1:0];
    end

endmodule

// File: conv1d_engine.sv
`include "conv_macros.svh"

module conv1d_engine (
    input  logic              s_clk,
    input  logic              s_rst,
    input  conv_pkg::wb_req_t wb_req,
    output conv_pkg::wb_rsp_t wb_rsp
);

    conv_pkg::weight_bank_t    weights;
    conv_pkg::quant_t          sample;
    logic                      issue;
    logic                      clear;
    logic                      pop;
    logic                      result_valid;
    conv_pkg::acc_t            result;
    conv_pkg::acc_t            head;
    logic                      empty;
    logic                      full;
    logic                      space;
    logic [`CONV_CNT_BITS-1:0] count;

    // host side, register map and sample issue
    wb_slave_port u_port (
        .s_clk   (s_clk),
        .s_rst   (s_rst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .space   (space),
        .head    (head),
        .empty   (empty),
        .full    (full),
        .count   (count),
        .weights (weights),
        .sample  (sample),
        .issue   (issue),
        .clear   (clear),
        .pop     (pop)
    );

    // nine-tap pe chain
    mac_chain u_chain (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .weights      (weights),
        .sample       (sample),
        .issue        (issue),
        .clear        (clear),
        .result_valid (result_valid),
        .result       (result)
    );

    // results wait here for the host
    result_fifo u_fifo (
        .s_clk (s_clk),
        .s_rst (s_rst),
        .issue (issue),
        .push  (result_valid),
        .din   (result),
        .pop   (pop),
        .head  (head),
        .empty (empty),
        .full  (full),
        .space (space),
        .count (count)
    );

endmodule

// File: conv1d_engine_assert.sv
module conv1d_engine_assert (
    input logic s_clk,
    input logic s_rst,
    input logic ack,
    input logic issue,
    input logic space,
    input logic pop,
    input logic empty,
    input logic result_valid
);

    // single-cycle ack per access
    ack_one_cycle: assert property (@(posedge s_clk) disable iff (s_rst) ack |=> !ack)
        else $error("bus ack stayed high for more than one cycle");

    // a sample only enters the chain with a reserved slot
    issue_has_space: assert property (@(posedge s_clk) disable iff (s_rst) issue |-> space)
        else $error("sample issued while the result fifo had no space");

    pop_not_empty: assert property (@(posedge s_clk) disable iff (s_rst) pop |-> !empty)
        else $error("result fifo popped while empty");

    // mult stage then add stage
    valid_latency: assert property (
        @(posedge s_clk) disable iff (s_rst) issue |-> ##2 result_valid)
        else $error("result_valid did not follow issue by two cycles");

endmodule

// File: conv1d_engine_tb.sv
`include "conv_macros.svh"

module conv1d_engine_tb;

    localparam int drive_dly    = 5;    // input change after the rising edge
    localparam int ack_timeout  = 40;   // cycles per bus access
    localparam int stall_cycles = 24;   // how long a blocked write is watched
    localparam int chain_cycles = 2;    // issue to result_valid

    logic              s_clk;
    logic              s_rst;
    conv_pkg::wb_req_t wb_req;
    conv_pkg::wb_rsp_t wb_rsp;

    int err_cnt;                  // wrong values and unexpected acks
    int tmo_cnt;                  // missing acks
    int model_w [`CONV_TAPS];     // weight per tap
    int model_x [`CONV_TAPS];     // index k holds x[n-k]
    int model_q [$];              // results the host has not read

    conv1d_engine DUT (
        .s_clk  (s_clk),
        .s_rst  (s_rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    bind conv1d_engine conv1d_engine_assert u_assert (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .ack          (wb_rsp.ack),
        .issue        (issue),
        .space        (space),
        .pop          (pop),
        .empty        (empty),
        .result_valid (result_valid)
    );

    always #20 s_clk = ~s_clk;

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            err_cnt++;
            $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    // one classic cycle where stall=1 expects no ack
    task automatic bus_access(input logic we, input int adr, input int dat,
                              input logic stall, output conv_pkg::wb_word_t rdat);
        int waited;
        int limit;
        limit = stall ? stall_cycles : ack_timeout;
        repeat ($urandom % 4) begin   // idle gap
            @(posedge s_clk);
            #drive_dly;
        end
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = conv_pkg::wb_adr_t'(adr);
        wb_req.dat_w = dat;
        rdat   = '0;
        waited = 0;
        do begin
            @(posedge s_clk);
            #drive_dly;                // ack and dat_r settled here
            waited++;
        end while (!wb_rsp.ack && waited < limit);
        if (wb_rsp.ack) begin
            rdat = wb_rsp.dat_r;
            if (stall) begin
                err_cnt++;
                $display("Sample write at %0t was acknowledged while the FIFO was full.", $time);
            end
        end else if (!stall) begin
            tmo_cnt++;
            $display("Timeout: address %0h got no acknowledge within %0d cycles.", adr, limit);
        end
        wb_req = '0;                   // drop cyc and stb
    endtask

    // lets samples still in the chain land in the fifo
    task automatic settle_pipeline();
        repeat (chain_cycles) @(posedge s_clk);
        #drive_dly;
    endtask

    // sample write plus reference model update
    task automatic write_sample(input int x);
        conv_pkg::wb_word_t rdat;
        int                 y;
        int                 k;
        bus_access(1'b1, `CONV_ADR_SAMPLE, x, 1'b0, rdat);
        for (k = `CONV_TAPS - 1; k > 0; k--)
            model_x[k] = model_x[k-1];
        model_x[0] = x;
        y = 0;
        for (k = 0; k < `CONV_TAPS; k++)
            y += model_w[k] * model_x[k];     // y[n] = sum w[k] x[n-k]
        model_q.push_back(y);
    endtask

    // pops one result and compares it
    task automatic read_result(input int expected);
        conv_pkg::wb_word_t rdat;
        settle_pipeline();
        bus_access(1'b0, `CONV_ADR_RESULT, 0, 1'b0, rdat);
        check_value("wb_rsp.dat_r result", expected, int'(rdat));
    endtask

    // status word built from the register map
    task automatic read_status(input int exp_count);
        conv_pkg::wb_word_t rdat;
        conv_pkg::wb_word_t exp_stat;
        exp_stat = exp_count;
        exp_stat[`CONV_STAT_EMPTY_BIT] = (exp_count == 0);
        exp_stat[`CONV_STAT_FULL_BIT]  = (exp_count == `CONV_FIFO_DEPTH);
        settle_pipeline();
        bus_access(1'b0, `CONV_ADR_STATUS, 0, 1'b0, rdat);
        check_value("wb_rsp.dat_r status", int'(exp_stat), int'(rdat));
    endtask

    initial begin
        int                 fd;
        string              line;
        logic [7:0]         op;
        int                 a;
        int                 b;
        int                 k;
        int                 exp_y;
        conv_pkg::wb_word_t rd_word;
        void'($urandom(32'hdc382695));
        s_clk   = 1'b0;
        s_rst   = 1'b1;
        wb_req  = '0;
        err_cnt = 0;
        tmo_cnt = 0;
        for (k = 0; k < `CONV_TAPS; k++) begin
            model_w[k] = 0;
            model_x[k] = 0;
        end
        repeat (8) @(posedge s_clk);
        #drive_dly;
        s_rst = 1'b0;

        fd = $fopen("conv1d_testdata.txt", "r");
        if (fd == 0) begin
            err_cnt++;
            $display("Could not open conv1d_testdata.txt for reading.");
        end
        while (fd != 0 && tmo_cnt == 0 && $fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#")
                continue;
            a = 0;
            b = 0;
            void'($sscanf(line, "%c %d %d", op, a, b));
            case (op)
                "W": begin                            // write weight then read it back
                    bus_access(1'b1, `CONV_ADR_WEIGHT0 + a, b, 1'b0, rd_word);
                    bus_access(1'b0, `CONV_ADR_WEIGHT0 + a, 0, 1'b0, rd_word);
                    check_value($sformatf("wb_rsp.dat_r weight[%0d]", a), b, int'(rd_word));
                    model_w[a] = b;
                end
                "C": begin
                    bus_access(1'b1, `CONV_ADR_CTRL, 1, 1'b0, rd_word);
                    for (k = 0; k < `CONV_TAPS; k++)
                        model_x[k] = 0;               // history before clear counts as zero
                end
                "X": write_sample(a);
                "R": begin
                    exp_y = (model_q.size() == 0) ? 0 : model_q.pop_front();  // empty reads 0
                    check_value("testdata result vs model", exp_y, a);
                    read_result(a);
                end
                "S": begin
                    check_value("testdata count vs model", model_q.size(), a);
                    read_status(a);
                end
                "B": begin                            // write against a full fifo
                    bus_access(1'b1, `CONV_ADR_SAMPLE, a, 1'b1, rd_word);
                    read_status(model_q.size());      // still full after the stall
                    exp_y = model_q.pop_front();
                    read_result(exp_y);               // frees one slot
                    write_sample(a);                  // withdrawn write now completes
                    while (model_q.size() > 0 && tmo_cnt == 0) begin
                        exp_y = model_q.pop_front();
                        read_result(exp_y);           // same order as written
                    end
                    read_status(0);
                end
                default: begin
                    err_cnt++;
                    $display("Unknown operation in the test data: %s", line);
                end
            endcase
        end
        if (fd != 0)
            $fclose(fd);

        $display("summary: %0d value errors, %0d timeouts", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: conv1d_engine.f
+incdir+.
conv_pkg.sv
mac_unit.sv
mac_chain.sv
result_fifo.sv
wb_slave_port.sv
conv1d_engine.sv
conv1d_engine_assert.sv
conv1d_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, then run and search the log for the pass line
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module conv1d_engine_tb -f conv1d_engine.f
./obj_dir/Vconv1d_engine_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "STATUS: PASS" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// File: conv1d_testdata.txt
# op a b: W tap weight | C clear | X sample | R expected result
# S expected fifo count | B sample write that must stall on a full fifo
S 0
W 0 3
W 1 -5
W 2 -128
W 3 127
W 4 7
W 5 1
W 6 -2
W 7 64
W 8 -1
C
X 1
X 0
X 0
X 0
X 0
X 0
X 0
X 0
S 8
R 3
R -5
R -128
R 127
R 7
R 1
R -2
R 64
X 0
R -1
R 0
S 0
X 100
R 300
C
X -128
X 127
X -128
R -384
R 1021
R 15365
X 1
X 2
X 3
X 4
X 5
X 6
X 7
X 8
S 8
B 9
